// ==== design/idu_config.svh ====
`ifndef IDU_CONFIG_SVH
`define IDU_CONFIG_SVH

// Major opcodes, inst[6:0]
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_SYSTEM      7'b1110011

// funct7, inst[31:25]
`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000  // sub, sra, srai
`define F7_MRET         7'b0011000

// Instruction ids
`define ID_ADD          6'd0
`define ID_SUB          6'd1
`define ID_SLL          6'd2
`define ID_SLT          6'd3
`define ID_SLTU         6'd4
`define ID_XOR          6'd5
`define ID_SRL          6'd6
`define ID_SRA          6'd7
`define ID_OR           6'd8
`define ID_AND          6'd9
`define ID_ADDI         6'd10
`define ID_SLTI         6'd11
`define ID_SLTIU        6'd12
`define ID_XORI         6'd13
`define ID_ORI          6'd14
`define ID_ANDI         6'd15
`define ID_SLLI         6'd16
`define ID_SRLI         6'd17
`define ID_SRAI         6'd18
`define ID_LUI          6'd19
`define ID_AUIPC        6'd20
`define ID_JAL          6'd21
`define ID_JALR         6'd22
`define ID_LB           6'd23
`define ID_LH           6'd24
`define ID_LW           6'd25
`define ID_LBU          6'd26
`define ID_LHU          6'd27
`define ID_SB           6'd28
`define ID_SH           6'd29
`define ID_SW           6'd30
`define ID_BEQ          6'd31
`define ID_BNE          6'd32
`define ID_BLT          6'd33
`define ID_BGE          6'd34
`define ID_BLTU         6'd35
`define ID_BGEU         6'd36
`define ID_CSRRW        6'd37
`define ID_CSRRS        6'd38
`define ID_ECALL        6'd39
`define ID_MRET         6'd40
`define ID_UNKNOWN      6'd63

// ALU operation codes, numbering shared with the execute stage
`define ALU_ADD         5'd0
`define ALU_BEQ         5'd1
`define ALU_SLTU        5'd2
`define ALU_BNE         5'd3
`define ALU_SUB         5'd4
`define ALU_OR          5'd5
`define ALU_XOR         5'd6
`define ALU_BGE         5'd7
`define ALU_SLLI        5'd8
`define ALU_AND         5'd9
`define ALU_SRLI        5'd10
`define ALU_SLT         5'd11
`define ALU_BLT         5'd12
`define ALU_BLTU        5'd13
`define ALU_BGEU        5'd14
`define ALU_SLL         5'd15
`define ALU_SRAI        5'd16
`define ALU_SW          5'd17
`define ALU_LW          5'd18
`define ALU_SRA         5'd19
`define ALU_SRL         5'd20
`define ALU_LBU         5'd21
`define ALU_SH          5'd22
`define ALU_SB          5'd23
`define ALU_LHU         5'd24
`define ALU_LB          5'd25
`define ALU_LH          5'd26
`define ALU_CSRRW       5'd27
`define ALU_CSRRS       5'd28
`define ALU_NONE        5'd31

// Next-PC kinds
`define PC_SEQ          3'd0
`define PC_JALR         3'd1
`define PC_JAL          3'd2
`define PC_BRANCH       3'd4
`define PC_TRAP         3'd5

// Operand B source
`define SRC2_IMM        2'd0
`define SRC2_RS2        2'd1
`define SRC2_FOUR       2'd2    // Link address pc + 4
`define SRC2_NONE       2'd3

// Operand A source
`define SRC1_RS1        2'd0
`define SRC1_PC         2'd1
`define SRC1_ZERO       2'd3

// Immediate formats
`define IMM_I           3'd0
`define IMM_U           3'd1
`define IMM_J           3'd2
`define IMM_S           3'd3
`define IMM_B           3'd4
`define IMM_SYS         3'd5    // No immediate

`endif

// ==== design/idu_pkg.sv ====
package idu_pkg;

    typedef logic [31:0] inst_t;     // Raw instruction word
    typedef logic [31:0] word_t;     // Immediate data
    typedef logic [4:0]  reg_idx_t;  // Register file index

    // Decode results
    typedef logic [5:0]  insn_id_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [2:0]  pc_sel_t;
    typedef logic [1:0]  opnd_sel_t; // Shared by operand A and B selects
    typedef logic [2:0]  imm_fmt_t;

endpackage

// ==== design/idu_ctrl_if.sv ====
`timescale 1ns/10ps

// Decoded control bundle, encoder to stage register
interface idu_ctrl_if;
    idu_pkg::alu_op_t   alu_op;
    idu_pkg::pc_sel_t   pc_sel;
    idu_pkg::opnd_sel_t src2_sel;
    idu_pkg::opnd_sel_t src1_sel;
    logic               rd_wen;
    logic               rs_ren;
    logic               csr_wen;
    logic               ecall;

    modport src (
        output alu_op, pc_sel, src2_sel, src1_sel,
        output rd_wen, rs_ren, csr_wen, ecall
    );

    modport dst (
        input alu_op, pc_sel, src2_sel, src1_sel,
        input rd_wen, rs_ren, csr_wen, ecall
    );
endinterface

// ==== design/insn_classifier.sv ====
`timescale 1ns/10ps
`include "idu_config.svh"

module insn_classifier (
    input  idu_pkg::inst_t    inst,
    output idu_pkg::insn_id_t insn_id
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        insn_id = `ID_UNKNOWN;
        case (opcode)
            `OPC_OP: begin
                if (funct7 == `F7_BASE) begin
                    case (funct3)
                        3'b000:  insn_id = `ID_ADD;
                        3'b001:  insn_id = `ID_SLL;
                        3'b010:  insn_id = `ID_SLT;
                        3'b011:  insn_id = `ID_SLTU;
                        3'b100:  insn_id = `ID_XOR;
                        3'b101:  insn_id = `ID_SRL;
                        3'b110:  insn_id = `ID_OR;
                        default: insn_id = `ID_AND;
                    endcase
                end else if (funct7 == `F7_ALT) begin
                    if (funct3 == 3'b000)
                        insn_id = `ID_SUB;
                    else if (funct3 == 3'b101)
                        insn_id = `ID_SRA;
                end
            end
            `OPC_OP_IMM: begin
                case (funct3)
                    3'b000: insn_id = `ID_ADDI;
                    3'b010: insn_id = `ID_SLTI;
                    3'b011: insn_id = `ID_SLTIU;
                    3'b100: insn_id = `ID_XORI;
                    3'b110: insn_id = `ID_ORI;
                    3'b111: insn_id = `ID_ANDI;
                    3'b001: if (funct7 == `F7_BASE) insn_id = `ID_SLLI;
                    default: begin                  // Right shifts
                        if (funct7 == `F7_BASE)
                            insn_id = `ID_SRLI;
                        else if (funct7 == `F7_ALT)
                            insn_id = `ID_SRAI;
                    end
                endcase
            end
            `OPC_LOAD: begin
                case (funct3)
                    3'b000:  insn_id = `ID_LB;
                    3'b001:  insn_id = `ID_LH;
                    3'b010:  insn_id = `ID_LW;
                    3'b100:  insn_id = `ID_LBU;
                    3'b101:  insn_id = `ID_LHU;
                    default: ;
                endcase
            end
            `OPC_STORE: begin
                case (funct3)
                    3'b000:  insn_id = `ID_SB;
                    3'b001:  insn_id = `ID_SH;
                    3'b010:  insn_id = `ID_SW;
                    default: ;
                endcase
            end
            `OPC_BRANCH: begin
                case (funct3)
                    3'b000:  insn_id = `ID_BEQ;
                    3'b001:  insn_id = `ID_BNE;
                    3'b100:  insn_id = `ID_BLT;
                    3'b101:  insn_id = `ID_BGE;
                    3'b110:  insn_id = `ID_BLTU;
                    3'b111:  insn_id = `ID_BGEU;
                    default: ;
                endcase
            end
            `OPC_JAL:   insn_id = `ID_JAL;
            `OPC_JALR:  if (funct3 == 3'b000) insn_id = `ID_JALR;
            `OPC_LUI:   insn_id = `ID_LUI;
            `OPC_AUIPC: insn_id = `ID_AUIPC;
            `OPC_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        if (funct7 == `F7_BASE)
                            insn_id = `ID_ECALL;
                        else if (funct7 == `F7_MRET)
                            insn_id = `ID_MRET;
                    end
                    3'b001:  insn_id = `ID_CSRRW;
                    3'b010:  insn_id = `ID_CSRRS;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// ==== design/ctrl_encoder.sv ====
`timescale 1ns/10ps
`include "idu_config.svh"

module ctrl_encoder (
    input  idu_pkg::insn_id_t insn_id,
    idu_ctrl_if.src           ctrl,
    output idu_pkg::imm_fmt_t imm_fmt
);

    // ALU code table
    always_comb begin
        case (insn_id)
            `ID_ADD, `ID_ADDI, `ID_LUI, `ID_AUIPC,
            `ID_JAL, `ID_JALR:             ctrl.alu_op = `ALU_ADD;
            `ID_SUB:                       ctrl.alu_op = `ALU_SUB;
            `ID_SLL:                       ctrl.alu_op = `ALU_SLL;
            `ID_SLLI:                      ctrl.alu_op = `ALU_SLLI;
            `ID_SLT, `ID_SLTI:             ctrl.alu_op = `ALU_SLT;
            `ID_SLTU, `ID_SLTIU:           ctrl.alu_op = `ALU_SLTU;
            `ID_XOR, `ID_XORI:             ctrl.alu_op = `ALU_XOR;
            `ID_OR, `ID_ORI:               ctrl.alu_op = `ALU_OR;
            `ID_AND, `ID_ANDI:             ctrl.alu_op = `ALU_AND;
            `ID_SRL:                       ctrl.alu_op = `ALU_SRL;
            `ID_SRLI:                      ctrl.alu_op = `ALU_SRLI;
            `ID_SRA:                       ctrl.alu_op = `ALU_SRA;
            `ID_SRAI:                      ctrl.alu_op = `ALU_SRAI;
            `ID_LB:                        ctrl.alu_op = `ALU_LB;
            `ID_LH:                        ctrl.alu_op = `ALU_LH;
            `ID_LW:                        ctrl.alu_op = `ALU_LW;
            `ID_LBU:                       ctrl.alu_op = `ALU_LBU;
            `ID_LHU:                       ctrl.alu_op = `ALU_LHU;
            `ID_SB:                        ctrl.alu_op = `ALU_SB;
            `ID_SH:                        ctrl.alu_op = `ALU_SH;
            `ID_SW:                        ctrl.alu_op = `ALU_SW;
            `ID_BEQ:                       ctrl.alu_op = `ALU_BEQ;
            `ID_BNE:                       ctrl.alu_op = `ALU_BNE;
            `ID_BLT:                       ctrl.alu_op = `ALU_BLT;
            `ID_BGE:                       ctrl.alu_op = `ALU_BGE;
            `ID_BLTU:                      ctrl.alu_op = `ALU_BLTU;
            `ID_BGEU:                      ctrl.alu_op = `ALU_BGEU;
            `ID_CSRRW:                     ctrl.alu_op = `ALU_CSRRW;
            `ID_CSRRS:                     ctrl.alu_op = `ALU_CSRRS;
            default:                       ctrl.alu_op = `ALU_NONE; // ecall, mret, unknown
        endcase
    end

    // Operand routing, enables and immediate format by instruction class
    always_comb begin
        ctrl.pc_sel   = `PC_SEQ;
        ctrl.src2_sel = `SRC2_NONE;
        ctrl.src1_sel = `SRC1_ZERO;
        ctrl.rd_wen   = 1'b0;
        ctrl.rs_ren   = 1'b0;
        ctrl.csr_wen  = 1'b0;
        ctrl.ecall    = 1'b0;
        imm_fmt       = `IMM_I;
        case (insn_id)
            `ID_ADD, `ID_SUB, `ID_SLL, `ID_SLT, `ID_SLTU,
            `ID_XOR, `ID_SRL, `ID_SRA, `ID_OR, `ID_AND: begin
                ctrl.src2_sel = `SRC2_RS2;
                ctrl.src1_sel = `SRC1_RS1;
                ctrl.rd_wen   = 1'b1;
                ctrl.rs_ren   = 1'b1;
            end
            `ID_ADDI, `ID_SLTI, `ID_SLTIU, `ID_XORI, `ID_ORI, `ID_ANDI,
            `ID_SLLI, `ID_SRLI, `ID_SRAI,
            `ID_LB, `ID_LH, `ID_LW, `ID_LBU, `ID_LHU: begin
                ctrl.src2_sel = `SRC2_IMM;
                ctrl.src1_sel = `SRC1_RS1;
                ctrl.rd_wen   = 1'b1;
                ctrl.rs_ren   = 1'b1;
            end
            `ID_SB, `ID_SH, `ID_SW: begin
                ctrl.src2_sel = `SRC2_IMM;               // Address = rs1 + imm
                ctrl.src1_sel = `SRC1_RS1;
                ctrl.rs_ren   = 1'b1;
                imm_fmt       = `IMM_S;
            end
            `ID_BEQ, `ID_BNE, `ID_BLT, `ID_BGE, `ID_BLTU, `ID_BGEU: begin
                ctrl.pc_sel   = `PC_BRANCH;
                ctrl.src2_sel = `SRC2_RS2;               // Compare rs1 with rs2
                ctrl.src1_sel = `SRC1_RS1;
                ctrl.rs_ren   = 1'b1;
                imm_fmt       = `IMM_B;
            end
            `ID_LUI, `ID_AUIPC: begin
                ctrl.src2_sel = `SRC2_IMM;
                ctrl.src1_sel = (insn_id == `ID_AUIPC) ? `SRC1_PC : `SRC1_ZERO;
                ctrl.rd_wen   = 1'b1;
                imm_fmt       = `IMM_U;
            end
            `ID_JAL, `ID_JALR: begin
                ctrl.src2_sel = `SRC2_FOUR;              // rd gets pc + 4
                ctrl.src1_sel = `SRC1_PC;
                ctrl.rd_wen   = 1'b1;
                if (insn_id == `ID_JAL) begin
                    ctrl.pc_sel = `PC_JAL;
                    imm_fmt     = `IMM_J;
                end else begin
                    ctrl.pc_sel = `PC_JALR;
                    ctrl.rs_ren = 1'b1;                  // Target base from rs1
                end
            end
            `ID_CSRRW, `ID_CSRRS: begin
                ctrl.src1_sel = `SRC1_RS1;
                ctrl.rd_wen   = 1'b1;
                ctrl.rs_ren   = 1'b1;
                ctrl.csr_wen  = 1'b1;
            end
            `ID_ECALL, `ID_MRET: begin
                ctrl.pc_sel = `PC_TRAP;
                ctrl.ecall  = (insn_id == `ID_ECALL);
                imm_fmt     = `IMM_SYS;
            end
            default: ;                                   // Unknown keeps all defaults
        endcase
    end

endmodule

// ==== design/imm_gen.sv ====
`timescale 1ns/10ps
`include "idu_config.svh"

module imm_gen (
    input  idu_pkg::inst_t    inst,
    input  idu_pkg::imm_fmt_t imm_fmt,
    output idu_pkg::word_t    imm
);

    logic sign;

    assign sign = inst[31];   // Sign bit sits at 31 in every format

    always_comb begin
        case (imm_fmt)
            `IMM_I:  imm = {{20{sign}}, inst[31:20]};
            `IMM_S:  imm = {{20{sign}}, inst[31:25], inst[11:7]};
            `IMM_B:  imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            `IMM_U:  imm = {inst[31:12], 12'b0};
            `IMM_J:  imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            `IMM_SYS: imm = '0;
            default: imm = '0;
        endcase
    end

endmodule

// ==== design/id_stage_reg.sv ====
`timescale 1ns/10ps
`include "idu_config.svh"

module id_stage_reg (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  idu_pkg::inst_t      inst,
    idu_ctrl_if.dst             ctrl,
    input  idu_pkg::word_t      imm,
    output logic                out_valid,
    output idu_pkg::alu_op_t    ex_alu_op,
    output idu_pkg::pc_sel_t    ex_pc_sel,
    output idu_pkg::opnd_sel_t  ex_src2_sel,
    output idu_pkg::opnd_sel_t  ex_src1_sel,
    output logic                ex_rd_wen,
    output logic                ex_rs_ren,
    output logic                ex_csr_wen,
    output logic                ex_ecall,
    output idu_pkg::word_t      ex_imm,
    output idu_pkg::reg_idx_t   ex_rd,
    output idu_pkg::reg_idx_t   ex_rs1,
    output idu_pkg::reg_idx_t   ex_rs2
);

    // Output valid and control fields
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            ex_alu_op  <= `ALU_NONE;
            ex_rd_wen  <= 1'b0;
            ex_rs_ren  <= 1'b0;
            ex_csr_wen <= 1'b0;
            ex_ecall   <= 1'b0;
        end else begin
            out_valid <= valid;
            if (valid) begin
                ex_alu_op  <= ctrl.alu_op;
                ex_rd_wen  <= ctrl.rd_wen;
                ex_rs_ren  <= ctrl.rs_ren;
                ex_csr_wen <= ctrl.csr_wen;
                ex_ecall   <= ctrl.ecall;
            end
        end
    end

    // Payload fields, held while valid is low
    always_ff @(posedge clk) begin
        if (valid) begin
            ex_pc_sel   <= ctrl.pc_sel;
            ex_src2_sel <= ctrl.src2_sel;
            ex_src1_sel <= ctrl.src1_sel;
            ex_imm      <= imm;
            ex_rd       <= inst[11:7];
            ex_rs1      <= inst[19:15];
            ex_rs2      <= inst[24:20];
        end
    end

endmodule

// ==== design/idu_top.sv ====
`timescale 1ns/10ps

module idu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid,
    input  idu_pkg::inst_t      inst,
    output logic                out_valid,
    output idu_pkg::alu_op_t    alu_op,
    output idu_pkg::pc_sel_t    pc_sel,
    output idu_pkg::opnd_sel_t  src2_sel,
    output idu_pkg::opnd_sel_t  src1_sel,
    output logic                rd_wen,
    output logic                rs_ren,
    output logic                csr_wen,
    output logic                ecall,
    output idu_pkg::word_t      imm,
    output idu_pkg::reg_idx_t   rd,
    output idu_pkg::reg_idx_t   rs1,
    output idu_pkg::reg_idx_t   rs2
);

    idu_pkg::insn_id_t insn_id;
    idu_pkg::imm_fmt_t imm_fmt;
    idu_pkg::word_t    imm_comb;    // Immediate before the stage register

    idu_ctrl_if ctrl_bus ();

    insn_classifier u_classifier (
        .inst    (inst),
        .insn_id (insn_id)
    );

    ctrl_encoder u_encoder (
        .insn_id (insn_id),
        .ctrl    (ctrl_bus.src),
        .imm_fmt (imm_fmt)
    );

    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm_comb)
    );

    id_stage_reg u_stage_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid       (valid),
        .inst        (inst),
        .ctrl        (ctrl_bus.dst),
        .imm         (imm_comb),
        .out_valid   (out_valid),
        .ex_alu_op   (alu_op),
        .ex_pc_sel   (pc_sel),
        .ex_src2_sel (src2_sel),
        .ex_src1_sel (src1_sel),
        .ex_rd_wen   (rd_wen),
        .ex_rs_ren   (rs_ren),
        .ex_csr_wen  (csr_wen),
        .ex_ecall    (ecall),
        .ex_imm      (imm),
        .ex_rd       (rd),
        .ex_rs1      (rs1),
        .ex_rs2      (rs2)
    );

endmodule

// ==== test/idu_checker.sv ====
`timescale 1ns/10ps
`include "idu_config.svh"

module idu_checker (
    input logic             clk,
    input logic             rst_n,
    input logic             valid,
    input logic             out_valid,
    input logic             rd_wen,
    input logic             csr_wen,
    input logic             ecall,
    input idu_pkg::pc_sel_t pc_sel
);

    // One-cycle stage latency
    a_out_valid_lat: assert property (
        @(posedge clk) disable iff (!rst_n) out_valid == $past(valid)
    ) else $error("out_valid is not valid delayed by one cycle");

    // CSR access always returns the old value to rd
    a_csr_writes_rd: assert property (
        @(posedge clk) disable iff (!rst_n) csr_wen |-> rd_wen
    ) else $error("csr_wen without rd_wen");

    a_ecall_traps: assert property (
        @(posedge clk) disable iff (!rst_n) ecall |-> (pc_sel == `PC_TRAP)
    ) else $error("ecall without a trap pc_sel");

endmodule

bind idu_top idu_checker u_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (valid),
    .out_valid (out_valid),
    .rd_wen    (rd_wen),
    .csr_wen   (csr_wen),
    .ecall     (ecall),
    .pc_sel    (pc_sel)
);

// ==== test/idu_tb.sv ====
`timescale 1ns/10ps
`include "idu_config.svh"

module idu_tb;

    localparam string STIM_FILE = "test/idu_stim.txt";
    localparam int    MAX_TESTS = 64;

    logic               clk;
    logic               rst_n;
    logic               valid;
    idu_pkg::inst_t     inst;
    logic               out_valid;
    idu_pkg::alu_op_t   alu_op;
    idu_pkg::pc_sel_t   pc_sel;
    idu_pkg::opnd_sel_t src2_sel;
    idu_pkg::opnd_sel_t src1_sel;
    logic               rd_wen;
    logic               rs_ren;
    logic               csr_wen;
    logic               ecall;
    idu_pkg::word_t     imm;
    idu_pkg::reg_idx_t  rd;
    idu_pkg::reg_idx_t  rs1;
    idu_pkg::reg_idx_t  rs2;

    logic [31:0] tab [MAX_TESTS][11];  // Test no, inst, then expected fields
    int          n_tests = 0;
    int          inflight[$];          // Rows waiting for their out_valid
    int          drv_row;
    int          done_cnt = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          timing_errs = 0;
    logic        exp_out_valid = 1'b0;
    logic        reset_checked = 1'b0;
    logic        loaded = 1'b0;
    logic [31:0] lcg_state;

    idu_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid     (valid),
        .inst      (inst),
        .out_valid (out_valid),
        .alu_op    (alu_op),
        .pc_sel    (pc_sel),
        .src2_sel  (src2_sel),
        .src1_sel  (src1_sel),
        .rd_wen    (rd_wen),
        .rs_ren    (rs_ren),
        .csr_wen   (csr_wen),
        .ecall     (ecall),
        .imm       (imm),
        .rd        (rd),
        .rs1       (rs1),
        .rs2       (rs2)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string field_name(input int f);
        case (f)
            2:       return "alu_op";
            3:       return "pc_sel";
            4:       return "src2_sel";
            5:       return "src1_sel";
            6:       return "rd_wen";
            7:       return "rs_ren";
            8:       return "csr_wen";
            9:       return "ecall";
            10:      return "imm";
            11:      return "rd";
            12:      return "rs1";
            default: return "rs2";
        endcase
    endfunction

    // Lines that do not parse as eleven fields are skipped
    task automatic load_stim();
        int          fd;
        int          cnt;
        int          num;
        string       line;
        logic [31:0] v [11];
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
            return;
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            if ($fgets(line, fd) == 0)
                break;
            cnt = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", num, v[1], v[2], v[3],
                          v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
            if (cnt == 11) begin
                tab[n_tests][0] = num;
                for (int i = 1; i < 11; i++)
                    tab[n_tests][i] = v[i];
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic finish_test(input string name, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("%s: pass", name);
        end else begin
            fail_cnt++;
            $display("%s: fail with %0d mismatches", name, errs);
        end
    endtask

    task automatic check_reset();
        int errs;
        errs = 0;
        assert (out_valid == 1'b0) else begin
            $display("FAILED at %0t: out_valid high during reset", $time);
            errs++;
        end
        assert ({rd_wen, rs_ren, csr_wen, ecall} == 4'b0) else begin
            $display("FAILED at %0t: enables not cleared by reset", $time);
            errs++;
        end
        assert (alu_op == `ALU_NONE) else begin
            $display("FAILED at %0t: alu_op %h after reset", $time, alu_op);
            errs++;
        end
        finish_test("reset", errs);
    endtask

    task automatic check_row(input int row);
        logic [31:0] got [14];
        logic [31:0] exp [14];
        logic [31:0] ins;
        int          errs;
        errs = 0;
        ins = tab[row][1];
        for (int f = 2; f < 11; f++)
            exp[f] = tab[row][f];
        exp[11] = 32'(ins[11:7]);          // Register fields straight from the word
        exp[12] = 32'(ins[19:15]);
        exp[13] = 32'(ins[24:20]);
        got[2]  = 32'(alu_op);
        got[3]  = 32'(pc_sel);
        got[4]  = 32'(src2_sel);
        got[5]  = 32'(src1_sel);
        got[6]  = 32'(rd_wen);
        got[7]  = 32'(rs_ren);
        got[8]  = 32'(csr_wen);
        got[9]  = 32'(ecall);
        got[10] = imm;
        got[11] = 32'(rd);
        got[12] = 32'(rs1);
        got[13] = 32'(rs2);
        for (int f = 2; f < 14; f++) begin
            assert (got[f] == exp[f]) else begin
                $display("FAILED at %0t: test %0d %s got %h expected %h",
                         $time, tab[row][0], field_name(f), got[f], exp[f]);
                errs++;
            end
        end
        finish_test($sformatf("test %0d", tab[row][0]), errs);
        done_cnt++;
    endtask

    // Outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (!reset_checked) begin
                check_reset();
                reset_checked = 1'b1;
            end
        end else begin
            assert (out_valid == exp_out_valid) else begin
                $display("FAILED at %0t: out_valid %b expected %b",
                         $time, out_valid, exp_out_valid);
                timing_errs++;
            end
            if (out_valid && inflight.size() > 0)
                check_row(inflight.pop_front());
            exp_out_valid = valid;         // Seen by the DUT at the next edge
            if (valid)
                inflight.push_back(drv_row);
        end
    end

    initial begin
        rst_n   <= 1'b0;
        valid   <= 1'b0;
        inst    <= '0;
        drv_row <= 0;
        lcg_state = 32'h17ad;
        load_stim();
        loaded = 1'b1;
        if (n_tests == 0) begin
            $display("No test could be read from %s", STIM_FILE);
            $display("Test failed");
        end else begin
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            for (int row = 0; row < n_tests; row++) begin
                lcg_state = lcg_next(lcg_state);
                repeat (lcg_state[17:16]) begin   // Idle gap of 0 to 3 cycles
                    @(posedge clk);
                    valid <= 1'b0;
                end
                @(posedge clk);
                valid   <= 1'b1;
                inst    <= tab[row][1];
                drv_row <= row;
            end
            @(posedge clk);
            valid <= 1'b0;
            wait (done_cnt == n_tests);
            @(posedge clk);
            $display("Summary: %0d passed, %0d failed, %0d out_valid errors",
                     pass_cnt, fail_cnt, timing_errs);
            if (fail_cnt == 0 && timing_errs == 0)
                $display("Test passed");
            else
                $display("Test failed");
        end
        $finish;
    end

    // Worst case per line is 3 idle cycles, the valid cycle and the check
    initial begin
        wait (loaded);
        repeat (n_tests * 5 + 20) @(posedge clk);
        $display("Timeout: only %0d of %0d tests finished in %0d cycles",
                 done_cnt, n_tests, n_tests * 5 + 20);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== test/idu_stim.txt ====
// num inst alu_op pc_sel src2_sel src1_sel rd_wen rs_ren csr_wen ecall imm
// All hex except num; rd, rs1 and rs2 are checked against the inst bit fields
1  003100B3 00 0 1 0 1 1 0 0 00000003
2  407302B3 04 0 1 0 1 1 0 0 00000407
3  00A49433 0F 0 1 0 1 1 0 0 0000000A
4  00D625B3 0B 0 1 0 1 1 0 0 0000000D
5  0107B733 02 0 1 0 1 1 0 0 00000010
6  013948B3 06 0 1 0 1 1 0 0 00000013
7  016ADA33 14 0 1 0 1 1 0 0 00000016
8  419C5BB3 13 0 1 0 1 1 0 0 00000419
9  01CDED33 05 0 1 0 1 1 0 0 0000001C
10 01FF7EB3 09 0 1 0 1 1 0 0 0000001F
11 FFF10093 00 0 0 0 1 1 0 0 FFFFFFFF
12 80022193 0B 0 0 0 1 1 0 0 FFFFF800
13 7FF33293 02 0 0 0 1 1 0 0 000007FF
14 55544393 06 0 0 0 1 1 0 0 00000555
15 F0056493 05 0 0 0 1 1 0 0 FFFFFF00
16 AAA67593 09 0 0 0 1 1 0 0 FFFFFAAA
17 00571693 08 0 0 0 1 1 0 0 00000005
18 01F85793 0A 0 0 0 1 1 0 0 0000001F
19 40795893 10 0 0 0 1 1 0 0 00000407
20 FFC10083 19 0 0 0 1 1 0 0 FFFFFFFC
21 00821183 1A 0 0 0 1 1 0 0 00000008
22 10032283 12 0 0 0 1 1 0 0 00000100
23 FFF44383 15 0 0 0 1 1 0 0 FFFFFFFF
24 00255483 18 0 0 0 1 1 0 0 00000002
25 FEB60FA3 17 0 0 0 0 1 0 0 FFFFFFFF
26 7ED71023 16 0 0 0 0 1 0 0 000007E0
27 80F82AA3 11 0 0 0 0 1 0 0 FFFFF815
28 00208863 01 4 1 0 0 1 0 0 00000010
29 FE419EE3 03 4 1 0 0 1 0 0 FFFFFFFC
30 0062C0E3 0C 4 1 0 0 1 0 0 00000800
31 8083D063 07 4 1 0 0 1 0 0 FFFFF000
32 06A4EF63 0D 4 1 0 0 1 0 0 0000007E
33 FEC5FFE3 0E 4 1 0 0 1 0 0 FFFFFFFE
34 FFFFF0EF 00 2 2 1 1 0 0 0 FFFFFFFE
35 0055A2EF 00 2 2 1 1 0 0 0 0005A804
36 00C100E7 00 1 2 1 1 1 0 0 0000000C
37 ABCDE1B7 00 0 0 3 1 0 0 0 ABCDE000
38 12345217 00 0 0 1 1 0 0 0 12345000
39 305312F3 1B 0 3 0 1 1 1 0 00000305
40 F14423F3 1C 0 3 0 1 1 1 0 FFFFFF14
41 00000073 1F 5 3 3 0 0 0 1 00000000
42 30200073 1F 5 3 3 0 0 0 0 00000000
43 403110B3 1F 0 3 3 0 0 0 0 00000403
44 FFFFF000 1F 0 3 3 0 0 0 0 FFFFFFFF

// ==== tb.f ====
+incdir+design
design/idu_pkg.sv
design/idu_ctrl_if.sv
design/insn_classifier.sv
design/ctrl_encoder.sv
design/imm_gen.sv
design/id_stage_reg.sv
design/idu_top.sv
test/idu_checker.sv
test/idu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module idu_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vidu_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test passed" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
